// ==== source/game_pkg.sv ====
/*
 * Playfield geometry, coordinate types and the game state encoding.
 * Imported by the piece, field and control modules of the sprint game.
 */
package game_pkg;

    // playfield size, row 0 at the top
    localparam int FIELD_ROWS = 20;
    localparam int FIELD_COLS = 10;

    typedef logic [4:0] row_t;
    typedef logic [3:0] col_t;

    // bit c set when column c of the row holds a locked tile
    typedef logic [FIELD_COLS-1:0] row_mask_t;

    // top-left cell of the O piece when it appears
    localparam row_t SPAWN_ROW = 5'd0;
    localparam col_t SPAWN_COL = 4'd4;

    // the 2x2 piece must leave room for its second row and column
    localparam row_t MAX_PIECE_ROW = row_t'(FIELD_ROWS - 2);
    localparam col_t MAX_PIECE_COL = col_t'(FIELD_COLS - 2);

    typedef enum logic [1:0] {
        READY,
        PLAYING,
        SPAWN_CHECK,
        GAME_OVER
    } game_state_t;

endpackage

// ==== source/timing_pkg.sv ====
/*
 * Key cooldown and sprint timer constants with the timer digit types.
 * TICK_CYCLES is short for simulation; on the board it is 5_000_000.
 */
package timing_pkg;

    // cycles an action stays blocked after it fires
    localparam int COOLDOWN_CYCLES = 8;

    // clock cycles per decisecond
    localparam int TICK_CYCLES = 50;

    // last value of each timer digit before it wraps
    localparam int DECIS_WRAP = 9;
    localparam int SEC_WRAP   = 59;
    localparam int MIN_WRAP   = 59;

    typedef logic [3:0] cooldown_t;
    typedef logic [5:0] tick_t;
    typedef logic [3:0] decis_t;
    typedef logic [5:0] sec_t;
    typedef logic [5:0] min_t;

endpackage

// ==== source/action_if.sv ====
/*
 * Player action pulses from the key conditioner to the piece and game logic.
 * Each signal is high for one cycle per accepted key action.
 */
interface action_if;

    logic move_left;
    logic move_right;
    logic soft_drop;
    logic hard_drop;

    modport src (output move_left, output move_right, output soft_drop, output hard_drop);

    modport dst (input move_left, input move_right, input soft_drop, input hard_drop);

endinterface

// ==== source/key_conditioner.sv ====
/*
 * Turns the four active-low push keys into rate-limited action pulses.
 * A held key repeats its action every COOLDOWN_CYCLES+1 cycles.
 */
module key_conditioner
    import timing_pkg::*;
(
    input  logic  clk,
    input  logic  rst_l,
    input  logic  key_left_n,
    input  logic  key_right_n,
    input  logic  key_soft_n,
    input  logic  key_hard_n,
    action_if.src act
);

    // bit order: left, right, soft drop, hard drop
    logic [3:0] key_meta;
    logic [3:0] key_sync;
    logic [3:0] fire;
    logic [3:0] pulse;
    cooldown_t  cooldown [4];

    // two-flop synchronizers, inverted to active high
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            key_meta <= '0;
            key_sync <= '0;
        end else begin
            key_meta <= ~{key_hard_n, key_soft_n, key_right_n, key_left_n};
            key_sync <= key_meta;
        end
    end

    // pressed and not cooling down
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            fire[i] = key_sync[i] && (cooldown[i] == '0);
        end
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            pulse <= '0;
            for (int i = 0; i < 4; i++) begin
                cooldown[i] <= '0;
            end
        end else begin
            pulse <= fire;
            for (int i = 0; i < 4; i++) begin
                if (fire[i]) begin
                    cooldown[i] <= cooldown_t'(COOLDOWN_CYCLES);
                end else if (cooldown[i] != '0) begin
                    cooldown[i] <= cooldown[i] - 1'b1;
                end
            end
        end
    end

    assign act.move_left  = pulse[0];
    assign act.move_right = pulse[1];
    assign act.soft_drop  = pulse[2];
    assign act.hard_drop  = pulse[3];

endmodule

// ==== source/piece_mover.sv ====
/*
 * Position of the falling O piece, given by its top-left cell.
 * Applies soft drop and side moves against walls and locked tiles, and
 * finds the landing row used by hard drop.
 */
module piece_mover
    import game_pkg::*;
(
    input  logic      clk,
    input  logic      rst_l,
    action_if.dst     act,
    input  logic      play_en,
    input  logic      lock,
    input  row_mask_t occupied [FIELD_ROWS],
    output row_t      piece_row,
    output col_t      piece_col,
    output row_t      land_row,
    output logic      spawn_blocked
);

    row_t row_next;
    col_t col_next;

    // all four cells of a 2x2 piece at (r, c) are empty
    function automatic logic cells_free(row_t r, col_t c);
        return !occupied[r][c] && !occupied[r][c + 1'b1] &&
               !occupied[r + 1'b1][c] && !occupied[r + 1'b1][c + 1'b1];
    endfunction

    always_comb begin
        row_next = piece_row;
        col_next = piece_col;
        if (lock) begin
            row_next = SPAWN_ROW;
            col_next = SPAWN_COL;
        end else if (play_en) begin
            if (act.soft_drop) begin
                if (piece_row < MAX_PIECE_ROW &&
                    cells_free(row_t'(piece_row + 1'b1), piece_col)) begin
                    row_next = piece_row + 1'b1;
                end
            end else if (act.move_left) begin
                if (piece_col != '0 &&
                    cells_free(piece_row, col_t'(piece_col - 1'b1))) begin
                    col_next = piece_col - 1'b1;
                end
            end else if (act.move_right) begin
                if (piece_col < MAX_PIECE_COL &&
                    cells_free(piece_row, col_t'(piece_col + 1'b1))) begin
                    col_next = piece_col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            piece_row <= SPAWN_ROW;
            piece_col <= SPAWN_COL;
        end else begin
            piece_row <= row_next;
            piece_col <= col_next;
        end
    end

    // walk down from the piece until the next row is blocked
    always_comb begin
        logic stopped;
        stopped  = 1'b0;
        land_row = piece_row;
        for (int r = 1; r <= int'(MAX_PIECE_ROW); r++) begin
            if (r > int'(piece_row) && !stopped) begin
                if (cells_free(row_t'(r), piece_col)) begin
                    land_row = row_t'(r);
                end else begin
                    stopped = 1'b1;
                end
            end
        end
    end

    assign spawn_blocked = !cells_free(SPAWN_ROW, SPAWN_COL);

endmodule

// ==== source/locked_field.sv ====
/*
 * Occupancy of every playfield cell with locked tiles.
 * A lock writes the O piece at its landing row; one row can be read out.
 */
module locked_field
    import game_pkg::*;
(
    input  logic      clk,
    input  logic      rst_l,
    input  logic      lock,
    input  row_t      land_row,
    input  col_t      piece_col,
    output row_mask_t occupied [FIELD_ROWS],
    input  row_t      field_row_sel,
    output row_mask_t field_row
);

    row_t land_row_lo;
    col_t piece_col_hi;

    assign land_row_lo  = land_row + 1'b1;
    assign piece_col_hi = piece_col + 1'b1;

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            for (int r = 0; r < FIELD_ROWS; r++) begin
                occupied[r] <= '0;
            end
        end else if (lock) begin
            occupied[land_row][piece_col]       <= 1'b1;
            occupied[land_row][piece_col_hi]    <= 1'b1;
            occupied[land_row_lo][piece_col]    <= 1'b1;
            occupied[land_row_lo][piece_col_hi] <= 1'b1;
        end
    end

    // rows past the bottom read as empty
    always_comb begin
        if (field_row_sel < row_t'(FIELD_ROWS)) begin
            field_row = occupied[field_row_sel];
        end else begin
            field_row = '0;
        end
    end

endmodule

// ==== source/game_control.sv ====
/*
 * Game flow FSM: ready screen, play, spawn check after a lock, game over.
 * Enables piece motion and the timer only while playing.
 */
module game_control
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        rst_l,
    action_if.dst       act,
    input  logic        spawn_blocked,
    output logic        play_en,
    output logic        lock,
    output logic        start,
    output game_state_t game_state
);

    game_state_t state;
    game_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            READY: begin
                if (act.soft_drop) begin
                    state_next = PLAYING;
                end
            end
            PLAYING: begin
                if (act.hard_drop) begin
                    state_next = SPAWN_CHECK;
                end
            end
            // field already holds the locked piece here
            SPAWN_CHECK: begin
                state_next = spawn_blocked ? GAME_OVER : PLAYING;
            end
            default: begin
                state_next = GAME_OVER;
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            state <= READY;
        end else begin
            state <= state_next;
        end
    end

    assign play_en    = (state == PLAYING);
    assign lock       = play_en && act.hard_drop;
    assign start      = (state == READY) && act.soft_drop;
    assign game_state = state;

endmodule

// ==== source/sprint_timer.sv ====
/*
 * Sprint clock in minutes, seconds and deciseconds.
 * Cleared by start, counts only while play is enabled.
 */
module sprint_timer
    import timing_pkg::*;
(
    input  logic   clk,
    input  logic   rst_l,
    input  logic   play_en,
    input  logic   start,
    output min_t   time_minutes,
    output sec_t   time_seconds,
    output decis_t time_deciseconds
);

    tick_t tick_cnt;
    logic  tick;

    assign tick = play_en && (tick_cnt == tick_t'(TICK_CYCLES - 1));

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            tick_cnt         <= '0;
            time_deciseconds <= '0;
            time_seconds     <= '0;
            time_minutes     <= '0;
        end else if (start) begin
            tick_cnt         <= '0;
            time_deciseconds <= '0;
            time_seconds     <= '0;
            time_minutes     <= '0;
        end else begin
            if (play_en) begin
                tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
            end
            // digits carry into the next one on wrap
            if (tick) begin
                if (time_deciseconds == decis_t'(DECIS_WRAP)) begin
                    time_deciseconds <= '0;
                    if (time_seconds == sec_t'(SEC_WRAP)) begin
                        time_seconds <= '0;
                        if (time_minutes == min_t'(MIN_WRAP)) begin
                            time_minutes <= '0;
                        end else begin
                            time_minutes <= time_minutes + 1'b1;
                        end
                    end else begin
                        time_seconds <= time_seconds + 1'b1;
                    end
                end else begin
                    time_deciseconds <= time_deciseconds + 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/tetris_top.sv ====
/*
 * Top level of the O-piece sprint game.
 * Keys come in active low; piece position, one field row, game state and
 * the sprint time go out for display.
 */
module tetris_top
    import game_pkg::*,
           timing_pkg::*;
(
    input  logic        clk,
    input  logic        rst_l,
    input  logic        key_left_n,
    input  logic        key_right_n,
    input  logic        key_soft_n,
    input  logic        key_hard_n,
    input  row_t        field_row_sel,
    output row_t        piece_row,
    output col_t        piece_col,
    output row_mask_t   field_row,
    output game_state_t game_state,
    output min_t        time_minutes,
    output sec_t        time_seconds,
    output decis_t      time_deciseconds
);

    logic      play_en;
    logic      lock;
    logic      start;
    logic      spawn_blocked;
    row_t      land_row;
    row_mask_t occupied [FIELD_ROWS];

    action_if u_act ();

    key_conditioner u_keys (
        .clk         (clk),
        .rst_l       (rst_l),
        .key_left_n  (key_left_n),
        .key_right_n (key_right_n),
        .key_soft_n  (key_soft_n),
        .key_hard_n  (key_hard_n),
        .act         (u_act.src)
    );

    piece_mover u_mover (
        .clk           (clk),
        .rst_l         (rst_l),
        .act           (u_act.dst),
        .play_en       (play_en),
        .lock          (lock),
        .occupied      (occupied),
        .piece_row     (piece_row),
        .piece_col     (piece_col),
        .land_row      (land_row),
        .spawn_blocked (spawn_blocked)
    );

    locked_field u_field (
        .clk           (clk),
        .rst_l         (rst_l),
        .lock          (lock),
        .land_row      (land_row),
        .piece_col     (piece_col),
        .occupied      (occupied),
        .field_row_sel (field_row_sel),
        .field_row     (field_row)
    );

    game_control u_ctrl (
        .clk           (clk),
        .rst_l         (rst_l),
        .act           (u_act.dst),
        .spawn_blocked (spawn_blocked),
        .play_en       (play_en),
        .lock          (lock),
        .start         (start),
        .game_state    (game_state)
    );

    sprint_timer u_timer (
        .clk              (clk),
        .rst_l            (rst_l),
        .play_en          (play_en),
        .start            (start),
        .time_minutes     (time_minutes),
        .time_seconds     (time_seconds),
        .time_deciseconds (time_deciseconds)
    );

endmodule

// ==== test/tb_clock.sv ====
/*
 * Testbench clock and reset: 20 ns clock period, with rst_l held low
 * for RESET_CYCLES rising edges.
 */
module tb_clock #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_l
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_l <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_l <= 1'b1;
    end

endmodule

// ==== test/tetris_tb.sv ====
/*
 * Testbench for the O-piece sprint game. Applies a table of key presses
 * and after each one checks the piece position, the state, one field row
 * and the sprint time.
 */
module tetris_tb
    import game_pkg::*, timing_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 10;
    localparam int MAX_GAP      = 3;

    typedef enum int {K_NONE, K_LEFT, K_RIGHT, K_SOFT, K_HARD} key_e;

    typedef struct {
        key_e        key;
        int          hold;
        row_t        row;
        col_t        col;
        game_state_t state;
        row_t        sel;
        row_mask_t   mask;
    } step_t;

    logic        clk;
    logic        rst_l;
    logic        key_left_n;
    logic        key_right_n;
    logic        key_soft_n;
    logic        key_hard_n;
    row_t        field_row_sel;
    row_t        piece_row;
    col_t        piece_col;
    row_mask_t   field_row;
    game_state_t game_state;
    min_t        time_minutes;
    sec_t        time_seconds;
    decis_t      time_deciseconds;

    step_t steps [$];
    int    play_cycles;
    int    cycle_cnt;
    int    timeout_limit;

    tb_clock #(.RESET_CYCLES(RESET_CYCLES)) u_clock (.clk(clk), .rst_l(rst_l));

    tetris_top u_dut (.*);

    task automatic stop_on_error();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pos(input row_t exp_row, input col_t exp_col);
        if (piece_row !== exp_row || piece_col !== exp_col) begin
            $display("** Error at %0t ns: piece at (%0d,%0d), expected (%0d,%0d)",
                     $time, piece_row, piece_col, exp_row, exp_col);
            stop_on_error();
        end
    endtask

    task automatic check_state(input game_state_t exp_state);
        if (game_state !== exp_state) begin
            $display("** Error at %0t ns: state %s, expected %s",
                     $time, game_state.name(), exp_state.name());
            stop_on_error();
        end
    endtask

    task automatic check_row(input row_t sel, input row_mask_t exp_mask);
        if (field_row !== exp_mask) begin
            $display("** Error at %0t ns: field row %0d is %b, expected %b",
                     $time, sel, field_row, exp_mask);
            stop_on_error();
        end
    endtask

    // one decisecond per TICK_CYCLES cycles spent in PLAYING
    task automatic check_time(input min_t m, input sec_t s, input decis_t d, input int tol);
        int got;
        int exp;
        got = int'(m) * 600 + int'(s) * 10 + int'(d);
        exp = play_cycles / TICK_CYCLES;
        if (got > exp + tol || got < exp - tol) begin
            $display("** Error at %0t ns: time %0d:%0d.%0d, expected %0d deciseconds",
                     $time, m, s, d, exp);
            stop_on_error();
        end
    endtask

    task automatic drive_key(input key_e key, input logic level);
        case (key)
            K_LEFT:  key_left_n  <= level;
            K_RIGHT: key_right_n <= level;
            K_SOFT:  key_soft_n  <= level;
            K_HARD:  key_hard_n  <= level;
            default: ;
        endcase
    endtask

    task automatic add_step(input key_e key, input int hold, input int row, input int col,
                            input game_state_t state, input int sel, input int mask);
        step_t s;
        s = '{key, hold, row_t'(row), col_t'(col), state, row_t'(sel), row_mask_t'(mask)};
        steps.push_back(s);
    endtask

    task automatic apply_step(input step_t s);
        int gap;
        gap = $urandom % (MAX_GAP + 1);
        repeat (gap + 1) @(posedge clk);
        field_row_sel <= s.sel;
        drive_key(s.key, 1'b0);
        repeat (s.hold) @(posedge clk);
        drive_key(s.key, 1'b1);
        repeat (IDLE_CYCLES) @(posedge clk);
        @(negedge clk);
        check_pos(s.row, s.col);
        check_state(s.state);
        check_row(s.sel, s.mask);
        check_time(time_minutes, time_seconds, time_deciseconds, 1);
    endtask

    task automatic build_table();
        // nothing moves on the ready screen, soft drop starts play
        add_step(K_LEFT, 1, 0, 4, READY, 19, 10'h000);
        add_step(K_RIGHT, 1, 0, 4, READY, 19, 10'h000);
        add_step(K_HARD, 1, 0, 4, READY, 19, 10'h000);
        add_step(K_SOFT, 1, 0, 4, PLAYING, 19, 10'h000);
        add_step(K_LEFT, 1, 0, 3, PLAYING, 19, 10'h000);
        add_step(K_RIGHT, 1, 0, 4, PLAYING, 19, 10'h000);
        add_step(K_RIGHT, 1, 0, 5, PLAYING, 19, 10'h000);
        // 28 held cycles repeat four times
        add_step(K_LEFT, 28, 0, 1, PLAYING, 19, 10'h000);
        add_step(K_LEFT, 1, 0, 0, PLAYING, 19, 10'h000);
        add_step(K_LEFT, 1, 0, 0, PLAYING, 19, 10'h000);
        add_step(K_RIGHT, 90, 0, 8, PLAYING, 19, 10'h000);
        add_step(K_SOFT, 200, 18, 8, PLAYING, 19, 10'h000);
        add_step(K_HARD, 1, 0, 4, PLAYING, 19, 10'h300);
        add_step(K_HARD, 1, 0, 4, PLAYING, 19, 10'h330);
        add_step(K_HARD, 1, 0, 4, PLAYING, 17, 10'h030);
        add_step(K_RIGHT, 1, 0, 5, PLAYING, 16, 10'h030);
        add_step(K_RIGHT, 1, 0, 6, PLAYING, 16, 10'h030);
        add_step(K_SOFT, 200, 18, 6, PLAYING, 18, 10'h330);
        // column 5 is locked next to the piece
        add_step(K_LEFT, 1, 18, 6, PLAYING, 18, 10'h330);
        add_step(K_HARD, 1, 0, 4, PLAYING, 18, 10'h3f0);
        for (int r = 14; r >= 2; r -= 2) begin
            add_step(K_HARD, 1, 0, 4, PLAYING, r, 10'h030);
        end
        add_step(K_HARD, 1, 0, 4, GAME_OVER, 0, 10'h030);
        add_step(K_LEFT, 1, 0, 4, GAME_OVER, 0, 10'h030);
        add_step(K_RIGHT, 1, 0, 4, GAME_OVER, 0, 10'h030);
        add_step(K_SOFT, 30, 0, 4, GAME_OVER, 1, 10'h030);
        add_step(K_HARD, 1, 0, 4, GAME_OVER, 18, 10'h3f0);
        add_step(K_NONE, 400, 0, 4, GAME_OVER, 19, 10'h3f0);
    endtask

    always @(posedge clk) begin
        if (game_state == PLAYING) begin
            play_cycles <= play_cycles + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: no result after %0d clock cycles", cycle_cnt);
            stop_on_error();
        end
    end

    initial begin
        int total;
        void'($urandom(32'hd2cf));
        key_left_n    <= 1'b1;
        key_right_n   <= 1'b1;
        key_soft_n    <= 1'b1;
        key_hard_n    <= 1'b1;
        field_row_sel <= '0;
        build_table();
        total = RESET_CYCLES + 2 * FIELD_ROWS;
        foreach (steps[i]) begin
            total += steps[i].hold + IDLE_CYCLES + MAX_GAP + 2;
        end
        timeout_limit = 2 * total;
        @(posedge rst_l);
        @(negedge clk);
        check_pos(5'd0, 4'd4);
        check_state(READY);
        check_time(time_minutes, time_seconds, time_deciseconds, 0);
        for (int r = 0; r < FIELD_ROWS; r++) begin
            @(posedge clk);
            field_row_sel <= row_t'(r);
            @(negedge clk);
            check_row(row_t'(r), '0);
        end
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== src.f ====
source/game_pkg.sv
source/timing_pkg.sv
source/action_if.sv
source/key_conditioner.sv
source/piece_mover.sv
source/locked_field.sv
source/game_control.sv
source/sprint_timer.sv
source/tetris_top.sv
test/tb_clock.sv
test/tetris_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module tetris_tb -f src.f -o tetris_sim
./obj_dir/tetris_sim 2>&1 | tee sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0
